/* logic/fpu_params.svh */
`ifndef FPU_PARAMS_SVH
`define FPU_PARAMS_SVH

`define FPU_ALEN        64  // register width
`define FPU_FLEN        32  // single precision
`define FPU_TAG_W       6
`define FPU_PIPE_STAGES 2   // execute latency
`define FPU_OP_W        4

`define FPU_OP_FSGNJ  4'd0
`define FPU_OP_FSGNJN 4'd1
`define FPU_OP_FSGNJX 4'd2
`define FPU_OP_FMIN   4'd3
`define FPU_OP_FMAX   4'd4
`define FPU_OP_FEQ    4'd5
`define FPU_OP_FLT    4'd6
`define FPU_OP_FLE    4'd7
`define FPU_OP_FCLASS 4'd8

`define FPU_CANON_NAN 32'h7fc00000  // quiet, positive

`endif

/* logic/fpu_pkg.sv */
`default_nettype none

`include "fpu_params.svh"

package fpu_pkg;

  // full register as held in the FP register file
  typedef logic [`FPU_ALEN-1:0] alen_t;

  // unboxed single value
  typedef logic [`FPU_FLEN-1:0] flen_t;

  // scheduler tag, returned with the result
  typedef logic [`FPU_TAG_W-1:0] tag_t;

  typedef logic [`FPU_OP_W-1:0] fpu_op_t;

  // {NV, DZ, OF, UF, NX}
  typedef logic [4:0] fflags_t;

  // one-hot FCLASS result, bit 0 is negative infinity
  typedef logic [9:0] class_mask_t;

endpackage

`default_nettype wire

/* logic/fpu_issue_if.sv */
`default_nettype none

interface fpu_issue_if;
  import fpu_pkg::*;

  logic    valid;
  fpu_op_t op;
  flen_t   a;  // already unboxed
  flen_t   b;
  tag_t    tag;

  modport decode (
    output valid,
    output op,
    output a,
    output b,
    output tag
  );

  modport exec (
    input valid,
    input op,
    input a,
    input b,
    input tag
  );

endinterface

`default_nettype wire

/* logic/fpu_exec_if.sv */
`default_nettype none

interface fpu_exec_if;
  import fpu_pkg::*;

  logic    valid;
  logic    is_fp;  // box on the way out
  flen_t   value;
  fflags_t fflags;
  tag_t    tag;

  modport exec (
    output valid,
    output is_fp,
    output value,
    output fflags,
    output tag
  );

  modport result (
    input valid,
    input is_fp,
    input value,
    input fflags,
    input tag
  );

endinterface

`default_nettype wire

/* logic/fpu_decode.sv */
`default_nettype none

`include "fpu_params.svh"

module fpu_decode (
  input logic             i_valid,
  input fpu_pkg::fpu_op_t i_op,
  input fpu_pkg::tag_t    i_tag,
  input fpu_pkg::alen_t   i_rs1,
  input fpu_pkg::alen_t   i_rs2,

  fpu_issue_if.decode     o_issue
);
  import fpu_pkg::*;

  logic  w_op_ok;
  flen_t w_a;
  flen_t w_b;

  // operand is only a single if the upper half is all ones
  function automatic flen_t unbox(input alen_t v);
    if (&v[`FPU_ALEN-1:`FPU_FLEN]) begin
      return v[`FPU_FLEN-1:0];
    end
    return `FPU_CANON_NAN;
  endfunction

  always_comb begin
    case (i_op)
      `FPU_OP_FSGNJ,
      `FPU_OP_FSGNJN,
      `FPU_OP_FSGNJX : w_op_ok = 1'b1;
      `FPU_OP_FMIN,
      `FPU_OP_FMAX   : w_op_ok = 1'b1;
      `FPU_OP_FEQ,
      `FPU_OP_FLT,
      `FPU_OP_FLE    : w_op_ok = 1'b1;
      `FPU_OP_FCLASS : w_op_ok = 1'b1;
      default        : w_op_ok = 1'b0;  // no unit for it
    endcase
  end

  assign w_a = unbox(i_rs1);
  assign w_b = unbox(i_rs2);

  assign o_issue.valid = i_valid & w_op_ok;
  assign o_issue.op    = i_op;
  assign o_issue.a     = w_a;
  assign o_issue.b     = w_b;
  assign o_issue.tag   = i_tag;

endmodule

`default_nettype wire

/* logic/fpu_noncomp_exec.sv */
`default_nettype none

`include "fpu_params.svh"

module fpu_noncomp_exec (
  input logic       i_clk,
  input logic       i_rst_n,

  fpu_issue_if.exec i_issue,
  fpu_exec_if.exec  o_exec
);
  import fpu_pkg::*;

  localparam int unsigned PIPE_STAGES = `FPU_PIPE_STAGES;

  flen_t       w_a;
  flen_t       w_b;
  class_mask_t w_a_class;
  class_mask_t w_b_class;
  logic        w_a_nan;
  logic        w_b_nan;
  logic        w_any_nan;
  logic        w_any_snan;
  logic        w_both_zero;
  logic        w_a_lt_tot;
  logic        w_lt;
  logic        w_eq;
  flen_t       w_minmax;

  logic        w_is_fp;
  logic        w_nv;
  flen_t       w_value;

  logic [PIPE_STAGES-1:0] r_valid;
  logic [PIPE_STAGES-1:0] r_is_fp;
  flen_t                  r_value  [PIPE_STAGES];
  fflags_t                r_fflags [PIPE_STAGES];
  tag_t                   r_tag    [PIPE_STAGES];

  function automatic class_mask_t classify(input flen_t v);
    logic [7:0]  exp;
    logic [22:0] man;
    class_mask_t mask;
    exp  = v[30:23];
    man  = v[22:0];
    mask = '0;
    if (exp == 8'hff && man != '0) begin
      mask[man[22] ? 9 : 8] = 1'b1;  // quiet bit picks qnan
    end else if (exp == 8'hff) begin
      mask[v[31] ? 0 : 7] = 1'b1;
    end else if (exp != '0) begin
      mask[v[31] ? 1 : 6] = 1'b1;
    end else if (man != '0) begin
      mask[v[31] ? 2 : 5] = 1'b1;
    end else begin
      mask[v[31] ? 3 : 4] = 1'b1;
    end
    return mask;
  endfunction

  assign w_a = i_issue.a;
  assign w_b = i_issue.b;

  assign w_a_class = classify(w_a);
  assign w_b_class = classify(w_b);

  assign w_a_nan     = w_a_class[8] | w_a_class[9];
  assign w_b_nan     = w_b_class[8] | w_b_class[9];
  assign w_any_nan   = w_a_nan | w_b_nan;
  assign w_any_snan  = w_a_class[8] | w_b_class[8];
  assign w_both_zero = (w_a_class[3] | w_a_class[4]) & (w_b_class[3] | w_b_class[4]);

  // sign-magnitude order, -0 sits below +0
  assign w_a_lt_tot = (w_a[31] != w_b[31]) ? w_a[31] :
                      w_a[31] ? (w_a[30:0] > w_b[30:0]) : (w_a[30:0] < w_b[30:0]);

  assign w_lt = w_a_lt_tot & ~w_both_zero;  // ieee ignores zero sign
  assign w_eq = (w_a == w_b) | w_both_zero;

  always_comb begin
    if (w_a_nan && w_b_nan) begin
      w_minmax = `FPU_CANON_NAN;
    end else if (w_a_nan) begin
      w_minmax = w_b;
    end else if (w_b_nan) begin
      w_minmax = w_a;
    end else if (i_issue.op == `FPU_OP_FMIN) begin
      w_minmax = w_a_lt_tot ? w_a : w_b;
    end else begin
      w_minmax = w_a_lt_tot ? w_b : w_a;
    end
  end

  always_comb begin
    w_is_fp = 1'b0;
    w_nv    = 1'b0;
    case (i_issue.op)
      `FPU_OP_FSGNJ : begin
        w_is_fp = 1'b1;
        w_value = {w_b[31], w_a[30:0]};
      end
      `FPU_OP_FSGNJN : begin
        w_is_fp = 1'b1;
        w_value = {~w_b[31], w_a[30:0]};
      end
      `FPU_OP_FSGNJX : begin
        w_is_fp = 1'b1;
        w_value = {w_a[31] ^ w_b[31], w_a[30:0]};
      end
      `FPU_OP_FMIN,
      `FPU_OP_FMAX : begin
        w_is_fp = 1'b1;
        w_nv    = w_any_snan;
        w_value = w_minmax;
      end
      `FPU_OP_FEQ : begin
        w_nv    = w_any_snan;  // quiet compare
        w_value = flen_t'(w_eq & ~w_any_nan);
      end
      `FPU_OP_FLT : begin
        w_nv    = w_any_nan;  // signaling compare
        w_value = flen_t'(w_lt & ~w_any_nan);
      end
      `FPU_OP_FLE : begin
        w_nv    = w_any_nan;
        w_value = flen_t'((w_lt | w_eq) & ~w_any_nan);
      end
      `FPU_OP_FCLASS : w_value = flen_t'(w_a_class);
      default        : w_value = '0;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      r_valid <= '0;
    end else begin
      r_valid[0] <= i_issue.valid;
      for (int i = 1; i < PIPE_STAGES; i++) begin
        r_valid[i] <= r_valid[i-1];
      end
    end
  end

  always_ff @(posedge i_clk) begin
    r_is_fp[0]  <= w_is_fp;
    r_value[0]  <= w_value;
    r_fflags[0] <= {w_nv, 4'b0000};  // DZ OF UF NX never raised here
    r_tag[0]    <= i_issue.tag;
    for (int i = 1; i < PIPE_STAGES; i++) begin
      r_is_fp[i]  <= r_is_fp[i-1];
      r_value[i]  <= r_value[i-1];
      r_fflags[i] <= r_fflags[i-1];
      r_tag[i]    <= r_tag[i-1];
    end
  end

  assign o_exec.valid  = r_valid[PIPE_STAGES-1];
  assign o_exec.is_fp  = r_is_fp[PIPE_STAGES-1];
  assign o_exec.value  = r_value[PIPE_STAGES-1];
  assign o_exec.fflags = r_fflags[PIPE_STAGES-1];
  assign o_exec.tag    = r_tag[PIPE_STAGES-1];

endmodule

`default_nettype wire

/* logic/fpu_result_pack.sv */
`default_nettype none

`include "fpu_params.svh"

module fpu_result_pack (
  input  logic              i_clk,
  input  logic              i_rst_n,

  fpu_exec_if.result        i_exec,

  output logic              o_valid,
  output fpu_pkg::alen_t    o_result,
  output fpu_pkg::fflags_t  o_fflags,
  output fpu_pkg::tag_t     o_tag
);
  import fpu_pkg::*;

  alen_t w_boxed;

  // fp results get a nan-box, compare bit and class mask zero-extend
  assign w_boxed = {{(`FPU_ALEN-`FPU_FLEN){i_exec.is_fp}}, i_exec.value};

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_valid  <= 1'b0;
      o_result <= '0;
      o_fflags <= '0;
      o_tag    <= '0;
    end else begin
      o_valid <= i_exec.valid;
      if (i_exec.valid) begin
        o_result <= w_boxed;
        o_fflags <= i_exec.fflags;
        o_tag    <= i_exec.tag;
      end else begin
        o_result <= '0;  // quiet bus when idle
        o_fflags <= '0;
        o_tag    <= '0;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/fpu_noncomp_top.sv */
`default_nettype none

module fpu_noncomp_top (
  input  logic             i_clk,
  input  logic             i_rst_n,

  input  logic             i_valid,
  input  fpu_pkg::fpu_op_t i_op,
  input  fpu_pkg::tag_t    i_tag,
  input  fpu_pkg::alen_t   i_rs1,
  input  fpu_pkg::alen_t   i_rs2,

  output logic             o_valid,
  output fpu_pkg::alen_t   o_result,
  output fpu_pkg::fflags_t o_fflags,
  output fpu_pkg::tag_t    o_tag
);

  fpu_issue_if issue_if ();
  fpu_exec_if  exec_if ();

  fpu_decode fpu_decode_i (
    .i_valid (i_valid ),
    .i_op    (i_op    ),
    .i_tag   (i_tag   ),
    .i_rs1   (i_rs1   ),
    .i_rs2   (i_rs2   ),
    .o_issue (issue_if)
  );

  fpu_noncomp_exec fpu_noncomp_exec_i (
    .i_clk   (i_clk   ),
    .i_rst_n (i_rst_n ),
    .i_issue (issue_if),
    .o_exec  (exec_if )
  );

  fpu_result_pack fpu_result_pack_i (
    .i_clk    (i_clk   ),
    .i_rst_n  (i_rst_n ),
    .i_exec   (exec_if ),
    .o_valid  (o_valid ),
    .o_result (o_result),
    .o_fflags (o_fflags),
    .o_tag    (o_tag   )
  );

endmodule

`default_nettype wire

/* testbench/fpu_noncomp_assert.sv */
`default_nettype none

`include "fpu_params.svh"

module fpu_noncomp_assert (
  input logic             i_clk,
  input logic             i_rst_n,
  input logic             i_valid,
  input fpu_pkg::fpu_op_t i_op,
  input logic             i_res_valid,
  input fpu_pkg::fflags_t i_res_fflags
);
  timeunit 1ns;
  timeprecision 100ps;
  import fpu_pkg::*;

  localparam int unsigned latency = `FPU_PIPE_STAGES + 1;

  int unsigned fail_cnt = 0;
  logic        w_issue;

  assign w_issue = i_valid && (i_op <= `FPU_OP_FCLASS);  // decoder accepts it

  valid_known: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !$isunknown(i_res_valid))
    else begin
      $error("o_valid is unknown after reset");
      fail_cnt++;
    end

  flags_shape: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_res_fflags[3:0] == 4'b0000)
    else begin
      $error("DZ, OF, UF or NX raised");
      fail_cnt++;
    end

  issue_to_result: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    w_issue |-> ##latency i_res_valid)
    else begin
      $error("o_valid missing %0d cycles after issue", latency);
      fail_cnt++;
    end

  result_has_issue: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_res_valid |-> $past(w_issue, latency))
    else begin
      $error("o_valid without a matching issue");
      fail_cnt++;
    end

endmodule

bind fpu_noncomp_top fpu_noncomp_assert fpu_noncomp_assert_i (
  .i_clk        (i_clk   ),
  .i_rst_n      (i_rst_n ),
  .i_valid      (i_valid ),
  .i_op         (i_op    ),
  .i_res_valid  (o_valid ),
  .i_res_fflags (o_fflags)
);

`default_nettype wire

/* testbench/tb_fpu_noncomp.sv */
`default_nettype none

`include "fpu_params.svh"

module tb_fpu_noncomp;
  timeunit 1ns;
  timeprecision 100ps;
  import fpu_pkg::*;

  localparam int unsigned latency = `FPU_PIPE_STAGES + 1;
  localparam int unsigned n_rand  = 64;

  localparam flen_t pos_one  = 32'h3f800000;
  localparam flen_t neg_one  = 32'hbf800000;
  localparam flen_t pos_two  = 32'h40000000;
  localparam flen_t neg_two  = 32'hc0000000;
  localparam flen_t pos_zero = 32'h00000000;
  localparam flen_t neg_zero = 32'h80000000;
  localparam flen_t pos_inf  = 32'h7f800000;
  localparam flen_t neg_inf  = 32'hff800000;
  localparam flen_t pos_sub  = 32'h00000001;
  localparam flen_t neg_sub  = 32'h80000001;
  localparam flen_t qnan     = 32'h7fc00000;
  localparam flen_t snan     = 32'h7f800001;

  localparam fflags_t nv       = 5'b10000;
  localparam fflags_t no_flags = 5'b00000;

  typedef struct packed {
    fpu_op_t op;
    alen_t   rs1;
    alen_t   rs2;
    alen_t   result;
    fflags_t fflags;
  } row_t;

  typedef struct packed {
    tag_t        tag;
    alen_t       result;
    fflags_t     fflags;
    int unsigned cyc;
  } exp_t;

  logic    i_clk;
  logic    i_rst_n;
  logic    i_valid;
  fpu_op_t i_op;
  tag_t    i_tag;
  alen_t   i_rs1;
  alen_t   i_rs2;
  logic    o_valid;
  alen_t   o_result;
  fflags_t o_fflags;
  tag_t    o_tag;

  row_t        rows[$];
  exp_t        exp_q[$];
  int unsigned cyc = 0;
  logic [31:0] rng_state = 32'h5ac5;
  fpu_op_t     rand_ops [6] = '{`FPU_OP_FSGNJ, `FPU_OP_FSGNJN, `FPU_OP_FSGNJX,
                                `FPU_OP_FEQ, `FPU_OP_FLT, `FPU_OP_FLE};

  fpu_noncomp_top fpu_noncomp_top_i (
    .i_clk    (i_clk   ),
    .i_rst_n  (i_rst_n ),
    .i_valid  (i_valid ),
    .i_op     (i_op    ),
    .i_tag    (i_tag   ),
    .i_rs1    (i_rs1   ),
    .i_rs2    (i_rs2   ),
    .o_valid  (o_valid ),
    .o_result (o_result),
    .o_fflags (o_fflags),
    .o_tag    (o_tag   )
  );

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  always @(posedge i_clk) cyc <= cyc + 1;

  function automatic alen_t box(input flen_t v);
    return {32'hffffffff, v};
  endfunction

  function automatic alen_t zext(input flen_t v);
    return {32'h00000000, v};
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic is_nan(input flen_t v);
    return (v[30:23] == 8'hff) && (v[22:0] != '0);
  endfunction

  // signed key where both zeros land on 0
  function automatic int signed order_key(input flen_t v);
    int signed mag;
    mag = int'({1'b0, v[30:0]});
    return v[31] ? -mag : mag;
  endfunction

  function automatic void ref_model(input fpu_op_t op, input flen_t a, input flen_t b,
                                    output alen_t res, output fflags_t ff);
    logic any_nan;
    logic any_snan;
    any_nan  = is_nan(a) || is_nan(b);
    any_snan = (is_nan(a) && !a[22]) || (is_nan(b) && !b[22]);
    res      = '0;
    ff       = no_flags;
    case (op)
      `FPU_OP_FSGNJ  : res = box({b[31], a[30:0]});
      `FPU_OP_FSGNJN : res = box({~b[31], a[30:0]});
      `FPU_OP_FSGNJX : res = box({a[31] ^ b[31], a[30:0]});
      `FPU_OP_FEQ : begin
        res = zext(32'(!any_nan && order_key(a) == order_key(b)));
        ff  = any_snan ? nv : no_flags;
      end
      `FPU_OP_FLT : begin
        res = zext(32'(!any_nan && order_key(a) < order_key(b)));
        ff  = any_nan ? nv : no_flags;
      end
      `FPU_OP_FLE : begin
        res = zext(32'(!any_nan && order_key(a) <= order_key(b)));
        ff  = any_nan ? nv : no_flags;
      end
      default : res = '0;
    endcase
  endfunction

  task automatic stop_failed();
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      stop_failed();
    end
  endtask

  task automatic watchdog(input int unsigned n_ops);
    int unsigned limit_ns;
    limit_ns = (n_ops + 10) * 4 * 4;
    #(limit_ns);
    $display("timeout: results still missing after %0d ns", limit_ns);
    stop_failed();
  endtask

  task automatic add_row(input fpu_op_t op, input alen_t rs1, input alen_t rs2,
                         input alen_t res, input fflags_t ff);
    rows.push_back('{op: op, rs1: rs1, rs2: rs2, result: res, fflags: ff});
  endtask

  task automatic build_table();
    add_row(`FPU_OP_FSGNJ,  box(pos_one), box(neg_two), box(neg_one), no_flags);
    add_row(`FPU_OP_FSGNJN, box(pos_one), box(neg_two), box(pos_one), no_flags);
    add_row(`FPU_OP_FSGNJX, box(neg_one), box(neg_two), box(pos_one), no_flags);
    add_row(`FPU_OP_FSGNJ,  box(qnan), box(neg_zero), box(32'hffc00000), no_flags);
    add_row(`FPU_OP_FMIN, box(neg_zero), box(pos_zero), box(neg_zero), no_flags);
    add_row(`FPU_OP_FMAX, box(neg_zero), box(pos_zero), box(pos_zero), no_flags);
    add_row(`FPU_OP_FMIN, box(pos_zero), box(neg_zero), box(neg_zero), no_flags);
    add_row(`FPU_OP_FMIN, box(qnan), box(pos_two), box(pos_two), no_flags);
    add_row(`FPU_OP_FMAX, box(snan), box(neg_one), box(neg_one), nv);
    add_row(`FPU_OP_FMAX, box(pos_one), box(qnan), box(pos_one), no_flags);
    add_row(`FPU_OP_FMIN, box(neg_two), box(snan), box(neg_two), nv);
    add_row(`FPU_OP_FMIN, box(qnan), box(snan), box(`FPU_CANON_NAN), nv);
    add_row(`FPU_OP_FMAX, box(neg_one), box(pos_two), box(pos_two), no_flags);
    add_row(`FPU_OP_FMIN, box(neg_two), box(neg_one), box(neg_two), no_flags);
    add_row(`FPU_OP_FEQ, box(pos_one), box(pos_one), zext(32'd1), no_flags);
    add_row(`FPU_OP_FEQ, box(pos_zero), box(neg_zero), zext(32'd1), no_flags);
    add_row(`FPU_OP_FEQ, box(qnan), box(pos_one), zext(32'd0), no_flags);
    add_row(`FPU_OP_FEQ, box(snan), box(pos_one), zext(32'd0), nv);
    add_row(`FPU_OP_FLT, box(neg_one), box(pos_one), zext(32'd1), no_flags);
    add_row(`FPU_OP_FLT, box(pos_one), box(pos_one), zext(32'd0), no_flags);
    add_row(`FPU_OP_FLT, box(qnan), box(pos_one), zext(32'd0), nv);
    add_row(`FPU_OP_FLE, box(pos_one), box(pos_one), zext(32'd1), no_flags);
    add_row(`FPU_OP_FLE, box(neg_zero), box(pos_zero), zext(32'd1), no_flags);
    add_row(`FPU_OP_FLE, box(pos_two), box(pos_one), zext(32'd0), no_flags);
    add_row(`FPU_OP_FLE, box(pos_one), box(qnan), zext(32'd0), nv);
    add_row(`FPU_OP_FCLASS, box(neg_inf),  box(pos_zero), zext(32'h001), no_flags);
    add_row(`FPU_OP_FCLASS, box(neg_one),  box(pos_zero), zext(32'h002), no_flags);
    add_row(`FPU_OP_FCLASS, box(neg_sub),  box(pos_zero), zext(32'h004), no_flags);
    add_row(`FPU_OP_FCLASS, box(neg_zero), box(pos_zero), zext(32'h008), no_flags);
    add_row(`FPU_OP_FCLASS, box(pos_zero), box(pos_zero), zext(32'h010), no_flags);
    add_row(`FPU_OP_FCLASS, box(pos_sub),  box(pos_zero), zext(32'h020), no_flags);
    add_row(`FPU_OP_FCLASS, box(pos_one),  box(pos_zero), zext(32'h040), no_flags);
    add_row(`FPU_OP_FCLASS, box(pos_inf),  box(pos_zero), zext(32'h080), no_flags);
    add_row(`FPU_OP_FCLASS, box(snan),     box(pos_zero), zext(32'h100), no_flags);
    add_row(`FPU_OP_FCLASS, box(qnan),     box(pos_zero), zext(32'h200), no_flags);
    // upper half not all ones, so these read as the canonical nan
    add_row(`FPU_OP_FCLASS, zext(pos_one), box(pos_zero), zext(32'h200), no_flags);
    add_row(`FPU_OP_FSGNJ, zext(pos_one), box(pos_one), box(`FPU_CANON_NAN), no_flags);
    add_row(`FPU_OP_FEQ, box(pos_one), 64'h12345678_3f800000, zext(32'd0), no_flags);
    add_row(4'd9, box(pos_one), box(pos_two), '0, no_flags);  // no unit
    add_row(`FPU_OP_FLT, box(pos_one), box(pos_two), zext(32'd1), no_flags);
    add_row(4'd15, box(pos_one), box(pos_two), '0, no_flags);
    add_row(`FPU_OP_FSGNJN, box(pos_two), box(pos_two), box(neg_two), no_flags);
    add_row(4'd12, box(neg_one), box(pos_one), '0, no_flags);
    add_row(`FPU_OP_FCLASS, box(neg_two), box(pos_zero), zext(32'h002), no_flags);
  endtask

  task automatic issue_op(input fpu_op_t op, input alen_t rs1, input alen_t rs2,
                          input tag_t tag, input alen_t res, input fflags_t ff);
    exp_t e;
    @(posedge i_clk);
    i_valid <= 1'b1;
    i_op    <= op;
    i_tag   <= tag;
    i_rs1   <= rs1;
    i_rs2   <= rs2;
    if (op <= `FPU_OP_FCLASS) begin
      e.tag    = tag;
      e.result = res;
      e.fflags = ff;
      e.cyc    = cyc + 1;  // number of this driving edge
      exp_q.push_back(e);
    end
  endtask

  always @(negedge i_clk) begin : monitor
    exp_t e;
    if (i_rst_n) begin
      compare_value("assert_fail_cnt",
                    64'(fpu_noncomp_top_i.fpu_noncomp_assert_i.fail_cnt), 64'd0);
      if (o_valid && exp_q.size() == 0) begin
        $display("o_valid went high with no operation in flight, tag 0x%h", o_tag);
        stop_failed();
      end else if (o_valid) begin
        e = exp_q.pop_front();
        compare_value("o_tag", 64'(o_tag), 64'(e.tag));
        compare_value("o_result", o_result, e.result);
        compare_value("o_fflags", 64'(o_fflags), 64'(e.fflags));
        compare_value("latency", 64'(cyc - e.cyc), 64'(latency));
      end else begin
        compare_value("o_result", o_result, 64'd0);  // idle bus stays zero
        compare_value("o_fflags", 64'(o_fflags), 64'd0);
        compare_value("o_tag", 64'(o_tag), 64'd0);
      end
    end
  end

  initial begin : stimulus
    flen_t       a;
    flen_t       b;
    logic [31:0] sel;
    fpu_op_t     op;
    alen_t       res;
    fflags_t     ff;
    i_rst_n = 1'b0;
    i_valid = 1'b0;
    i_op    = '0;
    i_tag   = '0;
    i_rs1   = '0;
    i_rs2   = '0;
    build_table();
    fork
      watchdog(rows.size() + n_rand);
    join_none
    repeat (2) @(posedge i_clk);
    i_rst_n <= 1'b1;

    foreach (rows[i]) begin
      issue_op(rows[i].op, rows[i].rs1, rows[i].rs2, tag_t'(i), rows[i].result,
               rows[i].fflags);
    end

    for (int i = 0; i < n_rand; i++) begin
      a   = next_rand();
      b   = next_rand();
      sel = next_rand();
      if (sel[1:0] == 2'd0) b = a;
      if (sel[4:2] == 3'd0) a[30:23] = 8'hff;  // inf or nan
      if (sel[7:5] == 3'd0) b[30:23] = 8'hff;
      op = rand_ops[sel[15:8] % 6];
      ref_model(op, a, b, res, ff);
      issue_op(op, box(a), box(b), tag_t'(rows.size() + i), res, ff);
    end

    @(posedge i_clk);
    i_valid <= 1'b0;
    while (exp_q.size() != 0) @(posedge i_clk);
    repeat (4) @(posedge i_clk);  // catch stray outputs

    if (fpu_noncomp_top_i.fpu_noncomp_assert_i.fail_cnt == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      $display("bound assertions failed during the run");
      stop_failed();
    end
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+logic
logic/fpu_pkg.sv
logic/fpu_issue_if.sv
logic/fpu_exec_if.sv
logic/fpu_decode.sv
logic/fpu_noncomp_exec.sv
logic/fpu_result_pack.sv
logic/fpu_noncomp_top.sv
testbench/fpu_noncomp_assert.sv
testbench/tb_fpu_noncomp.sv

/* Bender.yml */
package:
  name: fpu_noncomp

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/fpu_pkg.sv
      - logic/fpu_issue_if.sv
      - logic/fpu_exec_if.sv
      - logic/fpu_decode.sv
      - logic/fpu_noncomp_exec.sv
      - logic/fpu_result_pack.sv
      - logic/fpu_noncomp_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/fpu_noncomp_assert.sv
      - testbench/tb_fpu_noncomp.sv
